/* rtl/panel_pkg.sv */
package panel_pkg;

    localparam int unsigned color_depth = 6;  // Bits per colour channel.
    localparam int unsigned scan_rows = 16;   // Row addresses, each driving two lines.

    // Row address shared by the upper and the lower half.
    typedef logic [$clog2(scan_rows)-1:0] row_addr_t;

    // One-hot selector for the current bit plane.
    typedef logic [color_depth-1:0] plane_mask_t;

    typedef struct packed {
        logic [color_depth-1:0] r;  // Red intensity.
        logic [color_depth-1:0] g;  // Green intensity.
        logic [color_depth-1:0] b;  // Blue intensity.
    } rgb_pixel_t;

    // Host word and colour view of the same 18 bits.
    typedef union packed {
        logic [3*color_depth-1:0] raw;  // As written by the host, {r, g, b}.
        rgb_pixel_t               colors;  // Per channel view for plane select.
    } pixel_t;

    // One data line triple of the panel.
    typedef struct packed {
        logic r;  // Red shift input.
        logic g;  // Green shift input.
        logic b;  // Blue shift input.
    } rgb_bits_t;

endpackage

/* rtl/scan_pkg.sv */
package scan_pkg;

    // Enable time of the least significant plane in clk_in cycles.
    // Plane k is held for oe_base << k, so the top plane gets 736.
    localparam int unsigned oe_base = 23;

    // Remaining enable count below which the next line may start.
    // A line needs more cycles than this to reach its latch.
    localparam int unsigned overlap_start = 67;

    // Signals on the HUB75 connector.
    typedef struct packed {
        logic                  panel_clk;  // Gated shift clock.
        logic                  latch;      // Row latch strobe.
        logic                  oe;         // Output enable, high lights the LEDs.
        panel_pkg::row_addr_t  row_addr;   // Lines being lit.
        panel_pkg::rgb_bits_t  rgb0;       // Upper half data.
        panel_pkg::rgb_bits_t  rgb1;       // Lower half data.
    } hub75_out_t;

endpackage

/* rtl/timeout.sv */
`timescale 1ns/100ps

module timeout #(
    parameter int unsigned counter_width = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,    // Load strobe, takes priority.
    input  logic [counter_width-1:0] value,    // Interval length in cycles.
    output logic [counter_width-1:0] counter,  // Remaining cycles.
    output logic                     running   // High while counter is non-zero.
);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            counter <= '0;  // Idle after reset.
        end else if (start) begin
            counter <= value;  // Reload while start is held.
        end else if (counter != '0) begin
            counter <= counter - 1'b1;  // Count down.
        end
    end

    assign running = (counter != '0);  // One cycle per loaded count.

    // A zero load would give an interval that never runs.
    a_start_nonzero: assert property (
        @(posedge clk_in) disable iff (reset)
        start |-> (value != '0)
    );

endmodule

/* rtl/pixel_store.sv */
`timescale 1ns/100ps

module pixel_store #(
    parameter int unsigned columns = 64
) (
    input  logic                 clk_in,
    input  logic                 wr_en,      // Host write strobe.
    input  logic [4:0]           wr_line,    // Panel line, 16 and up is the lower half.
    input  logic [5:0]           wr_column,  // Column of the written pixel.
    input  panel_pkg::pixel_t    wr_pixel,   // Host pixel word.
    input  panel_pkg::row_addr_t rd_row,     // Scan row address.
    input  logic [5:0]           rd_column,  // Scan column address.
    output panel_pkg::pixel_t    upper,      // Pixel of line rd_row.
    output panel_pkg::pixel_t    lower       // Pixel of line rd_row + 16.
);

    import panel_pkg::*;

    pixel_t upper_mem [scan_rows][columns];  // Lines 0 to 15.
    pixel_t lower_mem [scan_rows][columns];  // Lines 16 to 31.

    row_addr_t wr_row;     // Line within the selected half.
    logic      wr_lower;  // Half select.

    assign wr_row   = wr_line[3:0];
    assign wr_lower = wr_line[4];

    // Host side, one write per cycle at most.
    always_ff @(posedge clk_in) begin
        if (wr_en && !wr_lower) begin
            upper_mem[wr_row][wr_column] <= wr_pixel;
        end
        if (wr_en && wr_lower) begin
            lower_mem[wr_row][wr_column] <= wr_pixel;
        end
    end

    // Scan side, both halves read together.
    always_ff @(posedge clk_in) begin
        upper <= upper_mem[rd_row][rd_column];  // Valid one cycle after the address.
        lower <= lower_mem[rd_row][rd_column];
    end

endmodule

/* rtl/bit_plane_select.sv */
`timescale 1ns/100ps

module bit_plane_select (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::pixel_t      upper,       // Upper half pixel from the store.
    input  panel_pkg::pixel_t      lower,       // Lower half pixel from the store.
    input  panel_pkg::plane_mask_t plane_mask,  // Plane of the address cycle.
    output panel_pkg::rgb_bits_t   rgb0,        // Upper half data lines.
    output panel_pkg::rgb_bits_t   rgb1         // Lower half data lines.
);

    import panel_pkg::*;

    plane_mask_t mask_q;  // Mask aligned with the read data.
    rgb_bits_t   bits0;   // Selected upper bits.
    rgb_bits_t   bits1;   // Selected lower bits.

    // One bit per channel, the one under the one-hot mask.
    function automatic rgb_bits_t plane_bits(input pixel_t pixel, input plane_mask_t mask);
        rgb_bits_t bits;
        bits.r = |(pixel.colors.r & mask);
        bits.g = |(pixel.colors.g & mask);
        bits.b = |(pixel.colors.b & mask);
        return bits;
    endfunction

    assign bits0 = plane_bits(upper, mask_q);
    assign bits1 = plane_bits(lower, mask_q);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            mask_q <= '0;
            rgb0   <= '0;  // Data lines low out of reset.
            rgb1   <= '0;
        end else begin
            mask_q <= plane_mask;  // Store read latency.
            rgb0   <= bits0;
            rgb1   <= bits1;
        end
    end

endmodule

/* rtl/matrix_scan.sv */
`timescale 1ns/100ps

module matrix_scan #(
    parameter int unsigned columns = 64
) (
    input  logic                   clk_in,
    input  logic                   reset,
    output logic [5:0]             column_address,      // Column being read now.
    output panel_pkg::row_addr_t   row_address,         // Row being shifted out.
    output panel_pkg::row_addr_t   row_address_active,  // Row currently lit.
    output panel_pkg::plane_mask_t plane_mask,          // Plane being shifted out.
    output logic                   pixel_clk_en,        // Enables the panel clock.
    output logic                   latch,               // Row latch pulse.
    output logic                   oe                   // Output enable window.
);

    import panel_pkg::*;
    import scan_pkg::*;

    localparam plane_mask_t msb_plane = plane_mask_t'(1) << (color_depth - 1);

    logic [1:0] state;         // State advance history, newest in bit 0.
    logic       state_advance;  // Next line allowed.
    logic       line_start;     // One-cycle start of a line load.
    logic       line_pending;   // Line started and not yet latched.
    logic       load_en;        // Read window of columns cycles.
    logic [2:0] load_pipe;      // Load window delayed by one, two and three.
    logic [9:0] oe_value;       // Enable time of the plane being latched.
    logic [9:0] oe_count;       // Remaining enable cycles.

    // Read window, one cycle per column.
    timeout #(
        .counter_width(7)
    ) i_load_window (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (7'(columns)),
        .counter(),
        .running(load_en)
    );

    // Column address counts columns-1 down to 0 alongside the window.
    timeout #(
        .counter_width(6)
    ) i_column_address (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (6'(columns - 1)),
        .counter(column_address),
        .running()
    );

    // Weight of the plane being latched, oe_base for bit 0.
    always_comb begin
        oe_value = 10'(oe_base);
        for (int k = 0; k < color_depth; k++) begin
            if (plane_mask[k]) begin
                oe_value = 10'(oe_base << k);
            end
        end
    end

    // Enable window, loaded by the latch.
    timeout #(
        .counter_width(10)
    ) i_output_enable (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (latch),
        .value  (oe_value),
        .counter(oe_count),
        .running(oe)
    );

    // Start shifting when dark or near the end of a long window.
    assign state_advance = !oe || (oe_count < 10'(overlap_start));
    assign line_start    = (state == 2'b11) && !line_pending;  // Seen for two cycles.

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state        <= 2'b00;
            line_pending <= 1'b0;
        end else begin
            if (latch) begin
                state <= 2'b00;  // Forget advances seen before the new window.
            end else begin
                state <= {state[0], state_advance};
            end
            if (line_start) begin
                line_pending <= 1'b1;  // One load per enable window.
            end else if (latch) begin
                line_pending <= 1'b0;
            end
        end
    end

    // Store read and plane select each take one cycle.
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            load_pipe <= 3'b000;
            latch     <= 1'b0;
        end else begin
            load_pipe <= {load_pipe[1:0], load_en};
            latch     <= load_pipe[2] & ~load_pipe[1];  // Two cycles after last clock.
        end
    end

    assign pixel_clk_en = load_pipe[1];  // Aligned with the registered data lines.

    // Latched row goes live, then move on to the next plane.
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            plane_mask         <= msb_plane;  // Start with the top plane of row 0.
            row_address        <= '0;
            row_address_active <= '0;
        end else if (latch) begin
            row_address_active <= row_address;
            if (plane_mask[0]) begin
                plane_mask  <= msb_plane;  // Last plane done.
                row_address <= row_address + 1'b1;  // Wraps from 15 to 0.
            end else begin
                plane_mask <= plane_mask >> 1;
            end
        end
    end

    // Shift register must be idle when its contents are transferred.
    a_latch_no_clock: assert property (
        @(posedge clk_in) disable iff (reset)
        latch |-> !pixel_clk_en
    );

    a_mask_onehot: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot(plane_mask)
    );

endmodule

/* rtl/hub75_top.sv */
`timescale 1ns/100ps

module hub75_top #(
    parameter int unsigned columns = 64
) (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  wr_en,      // Host write strobe.
    input  logic [4:0]            wr_line,    // Panel line 0 to 31.
    input  logic [5:0]            wr_column,  // Panel column.
    input  panel_pkg::pixel_t     wr_pixel,   // Pixel word.
    output scan_pkg::hub75_out_t  panel       // Connector signals.
);

    import panel_pkg::*;

    logic [5:0]  column_address;      // Scan read column.
    row_addr_t   row_address;         // Scan read row.
    row_addr_t   row_address_active;  // Row being lit.
    plane_mask_t plane_mask;          // Plane being shifted.
    logic        pixel_clk_en;        // Panel clock gate.
    logic        latch;               // Row latch.
    logic        oe;                  // Output enable.
    pixel_t      upper;               // Upper half read data.
    pixel_t      lower;               // Lower half read data.
    rgb_bits_t   rgb0;                // Upper half plane bits.
    rgb_bits_t   rgb1;                // Lower half plane bits.

    matrix_scan #(
        .columns(columns)
    ) i_matrix_scan (
        .clk_in            (clk_in),
        .reset             (reset),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .plane_mask        (plane_mask),
        .pixel_clk_en      (pixel_clk_en),
        .latch             (latch),
        .oe                (oe)
    );

    pixel_store #(
        .columns(columns)
    ) i_pixel_store (
        .clk_in   (clk_in),
        .wr_en    (wr_en),
        .wr_line  (wr_line),
        .wr_column(wr_column),
        .wr_pixel (wr_pixel),
        .rd_row   (row_address),
        .rd_column(column_address),
        .upper    (upper),
        .lower    (lower)
    );

    bit_plane_select i_bit_plane_select (
        .clk_in    (clk_in),
        .reset     (reset),
        .upper     (upper),
        .lower     (lower),
        .plane_mask(plane_mask),
        .rgb0      (rgb0),
        .rgb1      (rgb1)
    );

    // Panel clock is the low phase of clk_in, so it rises mid-cycle on settled data.
    assign panel = '{
        panel_clk: ~clk_in & pixel_clk_en,
        latch:     latch,
        oe:        oe,
        row_addr:  row_address_active,
        rgb0:      rgb0,
        rgb1:      rgb1
    };

endmodule

/* bench/tb_hub75.sv */
`timescale 1ns/100ps

module tb_hub75;

    import panel_pkg::*;
    import scan_pkg::*;

    localparam int num_tests = 5;
    localparam int clk_period = 8;                   // ns
    localparam int oe_lsb_cycles = 23;               // Enable time of plane 0.
    localparam longint watchdog_cycles = longint'(num_tests) * 2 * 16 * 6 * (64 + 736 + 10);
    localparam int fill_zero = 0;
    localparam int fill_ones = 1;
    localparam int fill_random = 2;
    localparam int fill_column = 3;                  // One column lit, value varies by line.
    localparam int fill_plane = 4;                   // Only one plane carries data.

    typedef struct {
        string name;     // Test name for error lines.
        int    pattern;  // Fill pattern.
        int    arg;      // Column or plane for the pattern.
        int    planes;   // Lines to compare after the frame is written.
    } test_t;

    logic        clk_in = 1'b0;
    logic        reset = 1'b1;
    logic        wr_en = 1'b0;
    logic [4:0]  wr_line = '0;
    logic [5:0]  wr_column = '0;
    pixel_t      wr_pixel = '0;
    hub75_out_t  panel;
    logic        panel_clk;

    test_t       tests [num_tests];
    logic [17:0] ref_frame [32][64];                 // Mirror of every host write.
    logic [2:0]  samples0 [64];                      // Upper data per panel clock.
    logic [2:0]  samples1 [64];                      // Lower data per panel clock.
    logic [31:0] lcg_state = 32'd94236;
    string       cur_name = "reset";
    int          pixels_total = 0;                   // Panel clocks since start.
    int          line_base = 0;                      // pixels_total at the last latch.
    int          exp_k = 5;                          // Plane of the line being shifted.
    int          exp_row = 0;                        // Row of the line being shifted.
    int          oe_k = 0;                           // Plane of the running enable window.
    int          active_row = 0;
    int          oe_width = 0;
    int          latch_count = 0;
    int          last_latched_k = 0;
    logic        row_check_due = 1'b0;
    logic        checking = 1'b0;                    // Data compare enabled.
    logic        wrapped = 1'b0;                     // Row went from 15 to 0.
    logic [3:0]  prev_row = '0;

    hub75_top #(
        .columns(64)
    ) i_dut (
        .clk_in   (clk_in),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_line  (wr_line),
        .wr_column(wr_column),
        .wr_pixel (wr_pixel),
        .panel    (panel)
    );

    assign panel_clk = panel.panel_clk;

    always #(clk_period / 2) clk_in = ~clk_in;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %0h, actual %0h", cur_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;  // Classic LCG step.
    endfunction

    // Bit k of each colour, packed as the panel data lines {r, g, b}.
    function automatic logic [2:0] plane_bits_of(input logic [17:0] raw, input int k);
        return {raw[12 + k], raw[6 + k], raw[k]};
    endfunction

    function automatic logic [17:0] fill_value(input int pattern, input int arg,
                                               input int line, input int column);
        logic [17:0] value;
        logic [2:0]  bits;
        value = '0;
        bits = 3'((line + column) % 7 + 1);  // Never all zero.
        case (pattern)
            fill_ones: value = '1;
            fill_column: begin
                if (column == arg) begin
                    value = 18'h3ffff ^ 18'(line);  // Lit, with line in the low bits.
                end
            end
            fill_plane: begin
                value[12 + arg] = bits[2];
                value[6 + arg] = bits[1];
                value[arg] = bits[0];
            end
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic load_table();
        tests[0] = '{"all_zero", fill_zero, 0, 12};
        tests[1] = '{"all_ones", fill_ones, 0, 12};
        tests[2] = '{"random", fill_random, 0, 24};
        tests[3] = '{"single_column", fill_column, 37, 12};
        tests[4] = '{"single_plane", fill_plane, 3, 12};
    endtask

    // Rewrites all 32 lines while the scan keeps running.
    task automatic write_frame(input int pattern, input int arg);
        logic [17:0] value;
        for (int line = 0; line < 32; line++) begin
            for (int column = 0; column < 64; column++) begin
                if (pattern == fill_random) begin
                    lcg_state = lcg_next(lcg_state);
                    value = lcg_state[30:13];
                end else begin
                    value = fill_value(pattern, arg, line, column);
                end
                @(posedge clk_in);
                wr_en <= 1'b1;
                wr_line <= 5'(line);
                wr_column <= 6'(column);
                wr_pixel.raw <= value;
                ref_frame[line][column] = value;
            end
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
    endtask

    task automatic wait_for_latch(output int plane);
        int start_count;
        start_count = latch_count;
        while (latch_count == start_count) @(posedge clk_in);
        plane = last_latched_k;
    endtask

    // Shifted bits, first clock is column 63.
    task automatic compare_line(input int row, input int k);
        int column;
        for (int i = 0; i < 64; i++) begin
            column = 63 - i;
            check_value($sformatf("rgb0 row %0d plane %0d column %0d", row, k, column),
                        32'(plane_bits_of(ref_frame[row][column], k)), 32'(samples0[i]));
            check_value($sformatf("rgb1 row %0d plane %0d column %0d", row + 16, k, column),
                        32'(plane_bits_of(ref_frame[row + 16][column], k)), 32'(samples1[i]));
        end
    endtask

    // Data lines are registered, so they are settled when the panel clock rises.
    always @(posedge panel_clk) begin
        int index;
        index = pixels_total - line_base;
        check_value("latch during panel clock", 0, 32'(panel.latch));
        if (index >= 0 && index < 64) begin
            samples0[index] = panel.rgb0;
            samples1[index] = panel.rgb1;
        end
        pixels_total = pixels_total + 1;
    end

    // Control lines sampled mid-cycle.
    always @(negedge clk_in) begin
        if (!reset) begin
            if (row_check_due) begin
                check_value("oe start after latch", 1, 32'(panel.oe));
                check_value("row address", 32'(active_row), 32'(panel.row_addr));
                if (prev_row == 4'd15 && panel.row_addr == 4'd0) begin
                    wrapped = 1'b1;
                end
                prev_row = panel.row_addr;
                row_check_due = 1'b0;
            end
            if (panel.latch) begin
                check_value("panel clocks per line", 64, 32'(pixels_total - line_base));
                if (checking) begin
                    compare_line(exp_row, exp_k);
                end
                line_base = pixels_total;
                oe_k = exp_k;
                active_row = exp_row;
                row_check_due = 1'b1;
                last_latched_k = exp_k;
                if (exp_k == 0) begin
                    exp_k = 5;                      // Back to the top plane.
                    exp_row = (exp_row + 1) % 16;   // Next row pair.
                end else begin
                    exp_k = exp_k - 1;
                end
                latch_count = latch_count + 1;
            end
            if (panel.oe) begin
                oe_width = oe_width + 1;
            end else if (oe_width != 0) begin
                check_value($sformatf("oe width plane %0d", oe_k), oe_lsb_cycles << oe_k,
                            32'(oe_width));
                oe_width = 0;
            end
        end
    end

    initial begin
        int plane;
        load_table();
        repeat (7) @(posedge clk_in);
        @(negedge clk_in);
        check_value("oe in reset", 0, 32'(panel.oe));
        check_value("latch in reset", 0, 32'(panel.latch));
        check_value("panel clock in reset", 0, 32'(panel.panel_clk));
        check_value("row address in reset", 0, 32'(panel.row_addr));
        @(posedge clk_in);
        reset <= 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            cur_name = tests[t].name;
            checking = 1'b0;
            write_frame(tests[t].pattern, tests[t].arg);
            do begin
                wait_for_latch(plane);
            end while (plane != 0);   // Next line is the top plane on new data.
            checking = 1'b1;
            repeat (tests[t].planes) wait_for_latch(plane);
            checking = 1'b0;
        end
        cur_name = "end";
        check_value("row wrap from 15 to 0", 1, 32'(wrapped));
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired: the panel scan did not get through all tests in time.");
        $display("Simulation failed");
        $fatal(1, "Watchdog timeout.");
    end

endmodule

/* verilog.f */
rtl/panel_pkg.sv
rtl/scan_pkg.sv
rtl/timeout.sv
rtl/pixel_store.sv
rtl/bit_plane_select.sv
rtl/matrix_scan.sv
rtl/hub75_top.sv
bench/tb_hub75.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_hub75 \
    -f verilog.f -o tb_hub75 > sim.log 2>&1 || { cat sim.log; echo "Build failed"; exit 1; }
./obj_dir/tb_hub75 >> sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "No result in sim.log"; exit 1; }
exit 0
